// File: Bender.yml
package:
  name: bank

sources:
  - bank_pkg.sv
  - apb_regs.sv
  - transaction_control.sv
  - key_hash.sv
  - balance_datapath.sv
  - account_ram.sv
  - bank_top.sv
  - target: simulation
    files:
      - tb_bank_top.sv

// File: account_ram.sv
// Single-port account memory with registered read data, one cycle of read latency
`default_nettype none

module account_ram #(
	parameter int ACCOUNT_COUNT = 16,
	localparam int INDEX_WIDTH = $clog2(ACCOUNT_COUNT)
) (
	input logic clock,
	input logic ram_read,
	input logic ram_write,
	input logic [INDEX_WIDTH-1:0] account,
	input bank_pkg::account_rec_t write_data,
	output bank_pkg::account_rec_t read_data
);
	import bank_pkg::*;

	// Undefined until the account is opened
	account_rec_t memory [ACCOUNT_COUNT];

	always_ff @(posedge clock)
	begin
		if (ram_write)
			memory[account] <= write_data;
		if (ram_read)
			read_data <= memory[account];  // Valid the following cycle
	end

endmodule

`default_nettype wire

// File: apb_regs.sv
// APB slave holding the host argument registers, status view and the transaction start pulse
`default_nettype none

module apb_regs #(
	parameter int ACCOUNT_COUNT = 16,
	localparam int INDEX_WIDTH = $clog2(ACCOUNT_COUNT)
) (
	input logic clock,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [7:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	input logic busy,
	input logic done,
	input bank_pkg::result_t result,
	input bank_pkg::balance_t balance,
	output logic start,
	output bank_pkg::command_t command,
	output logic [INDEX_WIDTH-1:0] account,
	output logic [7:0] key,
	output bank_pkg::amount_t amount
);
	import bank_pkg::*;

	logic access;
	logic locked;          // Transaction running or about to start
	logic known_address;
	logic ctrl_write;
	logic collision;
	logic accept;
	logic rejected;
	logic busy_q;
	command_t write_command;
	result_t status_result;

	assign access = psel & penable;
	assign locked = busy | start;
	assign write_command = command_t'(pwdata[1:0]);

	assign ctrl_write = access & pwrite & (paddr == REG_CTRL) & (write_command != CMD_NONE);
	assign collision = ctrl_write & locked;
	assign accept = ctrl_write & ~locked;

	assign pready = 1'b1;  // No wait states
	assign pslverr = access & (~known_address | collision);

	// A rejected write shows until the running transaction reports its own result
	assign status_result = rejected ? RES_REJECTED : result;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			start <= 1'b0;
			command <= CMD_NONE;
			rejected <= 1'b0;
			busy_q <= 1'b0;
		end
		else
		begin
			start <= accept;
			busy_q <= busy;
			if (accept)
			begin
				command <= write_command;
				rejected <= 1'b0;
			end
			else if (collision)
				rejected <= 1'b1;
			else if (busy_q & ~busy)
				rejected <= 1'b0;  // Finished transaction owns the result again
		end
	end

	// Arguments are frozen while a transaction runs
	always_ff @(posedge clock)
	begin
		if (access & pwrite & ~locked)
		begin
			case (paddr)
				REG_ACCOUNT: account <= pwdata[INDEX_WIDTH-1:0];
				REG_KEY: key <= pwdata[7:0];
				REG_AMOUNT: amount <= pwdata;
				default: ;
			endcase
		end
	end

	always_comb
	begin
		known_address = 1'b1;
		case (paddr)
			REG_CTRL: prdata = 32'(command);
			REG_ACCOUNT: prdata = 32'(account);
			REG_KEY: prdata = 32'(key);
			REG_AMOUNT: prdata = amount;
			REG_STATUS: prdata = {28'd0, status_result, done, locked};
			REG_BAL_LO: prdata = balance[31:0];
			REG_BAL_HI: prdata = 32'(balance[39:32]);
			default:
			begin
				prdata = '0;
				known_address = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: balance_datapath.sv
// Record register, tag check and balance arithmetic producing the verdict and the record to store
`default_nettype none

module balance_datapath (
	input logic clock,
	input logic reset,
	input logic load_record,
	input logic commit,
	input bank_pkg::command_t command,
	input bank_pkg::amount_t amount,
	input bank_pkg::tag_t tag,
	input bank_pkg::account_rec_t stored,
	output bank_pkg::result_t verdict,
	output bank_pkg::account_rec_t new_record,
	output bank_pkg::balance_t balance
);
	import bank_pkg::*;

	account_rec_t record;
	balance_t wide_amount;

	assign wide_amount = balance_t'(amount);

	always_ff @(posedge clock)
	begin
		if (load_record)
			record <= stored;
	end

	always_comb
	begin
		if (command == CMD_OPEN)
			verdict = RES_OK;  // Fresh record, nothing to check against
		else if (tag != record.tag)
			verdict = RES_BAD_KEY;
		else if (command == CMD_WITHDRAW && wide_amount > record.balance)
			verdict = RES_INSUFFICIENT;
		else
			verdict = RES_OK;
	end

	always_comb
	begin
		new_record.tag = tag;
		case (command)
			CMD_DEPOSIT: new_record.balance = record.balance + wide_amount;
			CMD_WITHDRAW: new_record.balance = record.balance - wide_amount;
			default: new_record.balance = wide_amount;  // Opening balance
		endcase
	end

	// Host-visible balance
	always_ff @(posedge clock)
	begin
		if (reset)
			balance <= '0;
		else if (commit)
			balance <= new_record.balance;
		else if (load_record)
			balance <= stored.balance;
	end

endmodule

`default_nettype wire

// File: bank.f
bank_pkg.sv
apb_regs.sv
transaction_control.sv
key_hash.sv
balance_datapath.sv
account_ram.sv
bank_top.sv
tb_bank_top.sv

// File: bank_pkg.sv
// Shared record layout, command and result codes and APB register map for the account engine
`default_nettype none

package bank_pkg;

	// Account payload pieces
	typedef logic [7:0] tag_t;      // Hash of the owner key
	typedef logic [39:0] balance_t;
	typedef logic [31:0] amount_t;

	// Stored record, tag on top
	typedef struct packed
	{
		tag_t tag;
		balance_t balance;
	} account_rec_t;

	typedef enum logic [1:0]
	{
		CMD_NONE,
		CMD_OPEN,
		CMD_DEPOSIT,
		CMD_WITHDRAW
	} command_t;

	typedef enum logic [1:0]
	{
		RES_OK,
		RES_BAD_KEY,
		RES_INSUFFICIENT,
		RES_REJECTED   // Command collided with a running one
	} result_t;

	localparam tag_t HASH_SEED = 8'h5A;

	// Byte offsets on the APB side
	localparam logic [7:0] REG_CTRL = 8'h00;
	localparam logic [7:0] REG_ACCOUNT = 8'h04;
	localparam logic [7:0] REG_KEY = 8'h08;
	localparam logic [7:0] REG_AMOUNT = 8'h0C;
	localparam logic [7:0] REG_STATUS = 8'h10;  // busy, done, result[3:2]
	localparam logic [7:0] REG_BAL_LO = 8'h14;
	localparam logic [7:0] REG_BAL_HI = 8'h18;

endpackage

`default_nettype wire

// File: bank_top.sv
// Account transaction engine top level, connecting the APB registers, sequencer, hash, datapath and RAM
`default_nettype none

module bank_top #(
	parameter int ACCOUNT_COUNT = 16,
	parameter int HASH_ROUNDS = 8
) (
	input logic clock,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [7:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr
);
	import bank_pkg::*;

	localparam int INDEX_WIDTH = $clog2(ACCOUNT_COUNT);

	// Host arguments
	logic start;
	command_t command;
	logic [INDEX_WIDTH-1:0] account;
	logic [7:0] key;
	amount_t amount;

	// Sequencer strobes and status
	logic busy;
	logic done;
	result_t result;
	logic ram_read;
	logic ram_write;
	logic hash_start;
	logic load_record;
	logic commit;

	// Datapath
	tag_t tag;
	logic hash_done;
	result_t verdict;
	account_rec_t stored;
	account_rec_t new_record;
	balance_t balance;

	apb_regs #(.ACCOUNT_COUNT(ACCOUNT_COUNT)) regs (.clock(clock), .reset(reset), .psel(psel),
		.penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
		.pready(pready), .pslverr(pslverr), .busy(busy), .done(done), .result(result),
		.balance(balance), .start(start), .command(command), .account(account), .key(key),
		.amount(amount));

	transaction_control control (.clock(clock), .reset(reset), .start(start), .command(command),
		.hash_done(hash_done), .verdict(verdict), .busy(busy), .done(done), .result(result),
		.ram_read(ram_read), .ram_write(ram_write), .hash_start(hash_start),
		.load_record(load_record), .commit(commit));

	key_hash #(.HASH_ROUNDS(HASH_ROUNDS)) hash (.clock(clock), .reset(reset),
		.hash_start(hash_start), .key(key), .tag(tag), .hash_done(hash_done));

	balance_datapath verdata (.clock(clock), .reset(reset), .load_record(load_record),
		.commit(commit), .command(command), .amount(amount), .tag(tag), .stored(stored),
		.verdict(verdict), .new_record(new_record), .balance(balance));

	account_ram #(.ACCOUNT_COUNT(ACCOUNT_COUNT)) ram (.clock(clock), .ram_read(ram_read),
		.ram_write(ram_write), .account(account), .write_data(new_record), .read_data(stored));

endmodule

`default_nettype wire

// File: key_hash.sv
// Multi-round key scrambler producing the account tag, started by a pulse and ending with hash_done
`default_nettype none

module key_hash #(
	parameter int HASH_ROUNDS = 8
) (
	input logic clock,
	input logic reset,
	input logic hash_start,
	input logic [7:0] key,
	output bank_pkg::tag_t tag,
	output logic hash_done
);
	import bank_pkg::*;

	localparam int ROUND_WIDTH = $clog2(HASH_ROUNDS + 1);
	localparam logic [ROUND_WIDTH-1:0] LAST_ROUND = ROUND_WIDTH'(HASH_ROUNDS - 1);

	logic running;
	logic [ROUND_WIDTH-1:0] round;

	// One round: rotate left, then mix in seed plus round number
	function automatic tag_t mix(input tag_t value, input logic [ROUND_WIDTH-1:0] index);
		return {value[6:0], value[7]} ^ (HASH_SEED + tag_t'(index));
	endfunction

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			running <= 1'b0;
			round <= '0;
			hash_done <= 1'b0;
		end
		else
		begin
			hash_done <= 1'b0;
			if (hash_start)
			begin
				round <= ROUND_WIDTH'(1);  // Round 0 applied at load
				running <= (HASH_ROUNDS > 1);
				hash_done <= (HASH_ROUNDS == 1);
			end
			else if (running)
			begin
				round <= round + 1'b1;
				if (round == LAST_ROUND)
				begin
					running <= 1'b0;
					hash_done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (hash_start)
			tag <= mix(key, '0);
		else if (running)
			tag <= mix(tag, round);
	end

endmodule

`default_nettype wire

// File: tb_bank_top.sv
// Directed testbench for the account engine, driving APB and checking against a reference model
`default_nettype none

module tb_bank_top;
	import bank_pkg::*;

	localparam int ACCOUNT_COUNT = 16;
	localparam int HASH_ROUNDS = 8;
	localparam int CLOCK_PERIOD = 4;
	localparam int RESET_CYCLES = 16;
	localparam int NUM_TRANSACTIONS = 13;
	// APB transfers take three clocks each on top of the sequencer run
	localparam int TIMEOUT =
		(RESET_CYCLES + NUM_TRANSACTIONS * 3 * (HASH_ROUNDS + 20)) * CLOCK_PERIOD;

	logic clock = 1'b0;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	logic [7:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;

	int result_errors = 0;
	int balance_errors = 0;
	int bus_errors = 0;
	int flag_errors = 0;

	// Model of every opened account
	balance_t exp_balance [ACCOUNT_COUNT];
	logic [7:0] exp_key [ACCOUNT_COUNT];

	bank_top #(.ACCOUNT_COUNT(ACCOUNT_COUNT), .HASH_ROUNDS(HASH_ROUNDS)) dut (.clock(clock),
		.reset(reset), .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr));

	always #(CLOCK_PERIOD / 2) clock = ~clock;

	// Rotate left, then XOR with seed plus round number
	function automatic tag_t ref_tag(input logic [7:0] key);
		tag_t value;
		value = key;
		for (int r = 0; r < HASH_ROUNDS; r++)
			value = {value[6:0], value[7]} ^ (HASH_SEED + tag_t'(r));
		return value;
	endfunction

	task automatic check_result(input string what, input result_t got, input result_t expected);
		if (got !== expected)
		begin
			result_errors++;
			$display("Mismatch at %0t: %s result %0d, expected %0d", $time, what, got, expected);
		end
	endtask

	task automatic check_balance(input string what, input balance_t got, input balance_t expected);
		if (got !== expected)
		begin
			balance_errors++;
			$display("Mismatch at %0t: %s 0x%0h, expected 0x%0h", $time, what, got, expected);
		end
	endtask

	task automatic check_error(input string what, input logic got, input logic expected);
		if (got !== expected)
		begin
			bus_errors++;
			$display("Mismatch at %0t: %s pslverr %b, expected %b", $time, what, got, expected);
		end
	endtask

	task automatic check_flag(input string what, input logic got, input logic expected);
		if (got !== expected)
		begin
			flag_errors++;
			$display("Mismatch at %0t: %s flag %b, expected %b", $time, what, got, expected);
		end
	endtask

	task automatic apb_transfer(input logic write, input logic [7:0] addr, input logic [31:0] data,
		output logic [31:0] rdata, output logic err);
		@(posedge clock);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= write;
		paddr <= addr;
		pwdata <= data;
		@(posedge clock);
		penable <= 1'b1;
		@(negedge clock);  // Middle of the access phase
		rdata = prdata;
		err = pslverr;
		check_flag("pready", pready, 1'b1);
		@(posedge clock);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
		logic [31:0] unused;
		apb_transfer(1'b1, addr, data, unused, err);
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
		apb_transfer(1'b0, addr, 32'd0, data, err);
	endtask

	task automatic start_command(input command_t cmd, input int acct, input logic [7:0] key,
		input amount_t amt);
		logic err;
		apb_write(REG_ACCOUNT, 32'(acct), err);
		check_error("account write", err, 1'b0);
		apb_write(REG_KEY, 32'(key), err);
		check_error("key write", err, 1'b0);
		apb_write(REG_AMOUNT, amt, err);
		check_error("amount write", err, 1'b0);
		apb_write(REG_CTRL, 32'(cmd), err);
		check_error("command write", err, 1'b0);
	endtask

	task automatic finish_command(input command_t cmd, input int acct, input logic [7:0] key,
		input amount_t amt);
		logic [31:0] status;
		logic [31:0] low;
		logic [31:0] high;
		logic err;
		result_t expected;
		balance_t wide;
		wide = balance_t'(amt);
		status = 32'd1;
		while (status[0])
			apb_read(REG_STATUS, status, err);
		apb_read(REG_STATUS, status, err);
		apb_read(REG_BAL_LO, low, err);
		apb_read(REG_BAL_HI, high, err);
		expected = RES_OK;
		if (cmd == CMD_OPEN)
		begin
			exp_key[acct] = key;
			exp_balance[acct] = wide;
		end
		else if (ref_tag(key) != ref_tag(exp_key[acct]))
			expected = RES_BAD_KEY;
		else if (cmd == CMD_WITHDRAW && wide > exp_balance[acct])
			expected = RES_INSUFFICIENT;
		else if (cmd == CMD_DEPOSIT)
			exp_balance[acct] += wide;
		else
			exp_balance[acct] -= wide;
		check_flag("done", status[1], 1'b1);
		check_result("status", result_t'(status[3:2]), expected);
		check_balance("balance", {high[7:0], low}, exp_balance[acct]);
	endtask

	task automatic run_command(input command_t cmd, input int acct, input logic [7:0] key,
		input amount_t amt);
		start_command(cmd, acct, key, amt);
		finish_command(cmd, acct, key, amt);
	endtask

	task automatic status_after_reset();
		logic [31:0] status;
		logic err;
		apb_read(REG_STATUS, status, err);
		check_error("status read", err, 1'b0);
		check_flag("busy after reset", status[0], 1'b0);
		check_flag("done after reset", status[1], 1'b0);
		check_result("after reset", result_t'(status[3:2]), RES_OK);
	endtask

	task automatic open_accounts();
		for (int a = 0; a < 3; a++)
			run_command(CMD_OPEN, a, 8'($urandom), $urandom & 32'h7FFF_FFFF);
		run_command(CMD_OPEN, 3, 8'($urandom), $urandom | 32'h8000_0000);  // Large balance
	endtask

	task automatic deposit_then_empty();
		run_command(CMD_DEPOSIT, 0, exp_key[0], $urandom & 32'h3FFF_FFFF);
		run_command(CMD_WITHDRAW, 0, exp_key[0], amount_t'(exp_balance[0]));  // Empties it
	endtask

	task automatic wrong_key_refused();
		run_command(CMD_DEPOSIT, 1, exp_key[1] ^ 8'h01, $urandom);
		run_command(CMD_DEPOSIT, 1, exp_key[1], 32'd0);  // Re-read
		run_command(CMD_WITHDRAW, 1, ~exp_key[1], 32'd1);
		run_command(CMD_DEPOSIT, 1, exp_key[1], 32'd0);
	endtask

	task automatic overdraw_refused();
		run_command(CMD_WITHDRAW, 2, exp_key[2], amount_t'(exp_balance[2]) + 32'd1);
		run_command(CMD_DEPOSIT, 2, exp_key[2], 32'd0);
	endtask

	task automatic bus_error_cases();
		logic [31:0] status;
		logic err;
		amount_t amt;
		amt = $urandom | 32'h8000_0000;  // Carries into the upper balance bits
		start_command(CMD_DEPOSIT, 3, exp_key[3], amt);
		apb_write(REG_CTRL, 32'(CMD_WITHDRAW), err);
		check_error("command while busy", err, 1'b1);
		apb_read(REG_STATUS, status, err);
		check_flag("busy during collision", status[0], 1'b1);
		check_result("collision", result_t'(status[3:2]), RES_REJECTED);
		finish_command(CMD_DEPOSIT, 3, exp_key[3], amt);
		apb_read(8'h1C, status, err);
		check_error("unknown address read", err, 1'b1);
		apb_write(8'h40, 32'hDEAD_BEEF, err);
		check_error("unknown address write", err, 1'b1);
	endtask

	initial
	begin
		void'($urandom(89733));
		reset <= 1'b1;
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
		paddr <= 8'd0;
		pwdata <= 32'd0;
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;
		status_after_reset();
		open_accounts();
		deposit_then_empty();
		wrong_key_refused();
		overdraw_refused();
		bus_error_cases();
		$display("Errors: result %0d, balance %0d, bus %0d, flag %0d",
			result_errors, balance_errors, bus_errors, flag_errors);
		if (result_errors + balance_errors + bus_errors + flag_errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	// Watchdog
	initial
	begin
		#(TIMEOUT);
		$display("The run timed out at %0t before all tests finished", $time);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: transaction_control.sv
// Sequencer FSM stepping each account transaction through read, hash, check and write
`default_nettype none

module transaction_control (
	input logic clock,
	input logic reset,
	input logic start,
	input bank_pkg::command_t command,
	input logic hash_done,
	input bank_pkg::result_t verdict,
	output logic busy,
	output logic done,
	output bank_pkg::result_t result,
	output logic ram_read,
	output logic ram_write,
	output logic hash_start,
	output logic load_record,
	output logic commit
);
	import bank_pkg::*;

	typedef enum logic [2:0]
	{
		S_IDLE,
		S_READ,
		S_LOAD,
		S_HASH,
		S_CHECK,
		S_WRITE,
		S_FINISH   // Waiting with done raised
	} state_t;

	state_t state;
	state_t next_state;
	logic is_open;

	assign is_open = (command == CMD_OPEN);

	always_comb
	begin
		next_state = state;
		case (state)
			S_IDLE, S_FINISH:
				if (start)
					next_state = is_open ? S_LOAD : S_READ;  // Open has nothing to read
			S_READ: next_state = S_LOAD;
			S_LOAD: next_state = S_HASH;
			S_HASH:
				if (hash_done)
					next_state = is_open ? S_WRITE : S_CHECK;
			S_CHECK: next_state = (verdict == RES_OK) ? S_WRITE : S_FINISH;
			S_WRITE: next_state = S_FINISH;
			default: next_state = S_IDLE;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= S_IDLE;
			result <= RES_OK;
		end
		else
		begin
			state <= next_state;
			if (state == S_CHECK && verdict != RES_OK)
				result <= verdict;
			else if (state == S_WRITE)
				result <= RES_OK;
		end
	end

	// Moore outputs
	assign busy = (state != S_IDLE) && (state != S_FINISH);
	assign done = (state == S_FINISH);
	assign ram_read = (state == S_READ);
	assign load_record = (state == S_LOAD) && !is_open;  // RAM data valid here
	assign hash_start = (state == S_LOAD);
	assign ram_write = (state == S_WRITE);
	assign commit = (state == S_WRITE);

endmodule

`default_nettype wire
